//--- tb.f
hdl/noc_pkg.sv
hdl/noc_input_fifo.sv
hdl/noc_lookahead_route.sv
hdl/noc_input_port.sv
hdl/noc_output_arbiter.sv
hdl/noc_output_port.sv
hdl/noc_router.sv
sim/tb_clock.sv
sim/tb_noc_router.sv

//--- Makefile
VERILATOR := verilator
FLAGS     := --binary --timing -Wno-fatal
TOP       := tb_noc_router
FILELIST  := tb.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_TEXT := Testbench passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- sim/tb_noc_router.sv
////////////////////
// Mesh router testbench
// Random worms on all five links, scoreboard per output
// Latency, ordering and hold checks
// Watchdog and closing report
////////////////////

`timescale 1ns/10ps
`default_nettype none

module tb_noc_router;

    import noc_pkg::*;

    localparam xy_t router_pos = '{x: 3'd3, y: 3'd3};
    localparam int packets_total = 138;
    localparam int watchdog_ns = packets_total * 4 * 5 * 8 * 4;
    localparam int drain_cycles = 4000;

    logic                  clk;
    logic                  rst;
    flit_t                 data_in [num_ports];
    flit_t                 data_out [num_ports];
    logic [num_ports-1:0]  void_in = '1;
    logic [num_ports-1:0]  stop_in = '0;
    logic [num_ports-1:0]  void_out;
    logic [num_ports-1:0]  stop_out;

    // Expected flits by input and output
    logic [flit_width-1:0] exp_q [num_ports][num_ports][$];
    // Input whose worm holds each output (-1 when idle)
    int                    worm_src [num_ports] = '{default: -1};
    logic [num_ports-1:0]  prev_void = '1;
    logic [num_ports-1:0]  prev_stop = '0;
    flit_t                 prev_data [num_ports];
    logic [31:0]           rand_state = 32'h12a8;
    logic                  stop_random = 1'b0;
    int                    checks = 0;
    int                    errors = 0;
    int                    tests_run = 0;
    int                    tests_failed = 0;

    tb_clock #(
        .period_ns    (4),
        .reset_cycles (5)
    ) u_clock (
        .clk_o (clk),
        .rst_o (rst)
    );

    noc_router UUT (
        .clk        (clk),
        .rst        (rst),
        .position_i (router_pos),
        .data_n_i   (data_in[port_north]),
        .data_s_i   (data_in[port_south]),
        .data_w_i   (data_in[port_west]),
        .data_e_i   (data_in[port_east]),
        .data_p_i   (data_in[port_local]),
        .void_i     (void_in),
        .stop_o     (stop_out),
        .data_n_o   (data_out[port_north]),
        .data_s_o   (data_out[port_south]),
        .data_w_o   (data_out[port_west]),
        .data_e_o   (data_out[port_east]),
        .data_p_o   (data_out[port_local]),
        .void_o     (void_out),
        .stop_i     (stop_in)
    );

    ////////////////////
    // Helpers

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic next_random_bit();
        logic fb;
        fb = rand_state[31] ^ rand_state[21] ^ rand_state[1] ^ rand_state[0];
        rand_state = {rand_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], next_random_bit()};
        end
        return v;
    endfunction

    // Any port but the one the packet came in on
    function automatic int random_other(input int p);
        int o;
        o = p;
        while (o == p) begin
            o = int'(random_bits(3)) % 5;
        end
        return o;
    endfunction

    // XY decision as seen from the neighbor the flit moves to
    function automatic dir_t expected_route(input dir_t leave, input xy_t dest);
        int   nx;
        int   ny;
        dir_t r;
        nx = int'(router_pos.x);
        ny = int'(router_pos.y);
        case (leave)
            go_north: ny = ny - 1;
            go_south: ny = ny + 1;
            go_west:  nx = nx - 1;
            go_east:  nx = nx + 1;
            default:  ny = ny;
        endcase
        if (int'(dest.x) > nx) begin
            r = go_east;
        end else if (int'(dest.x) < nx) begin
            r = go_west;
        end else if (int'(dest.y) > ny) begin
            r = go_south;
        end else if (int'(dest.y) < ny) begin
            r = go_north;
        end else begin
            r = go_local;
        end
        return r;
    endfunction

    function automatic string port_name(input int p);
        case (p)
            0: return "n";
            1: return "s";
            2: return "w";
            3: return "e";
            default: return "p";
        endcase
    endfunction

    function automatic int pending_flits();
        int n;
        n = 0;
        for (int p = 0; p < num_ports; p++) begin
            for (int o = 0; o < num_ports; o++) begin
                n += exp_q[p][o].size();
            end
        end
        return n;
    endfunction

    task automatic step_clock();
        @(posedge clk);
        #1;
    endtask

    ////////////////////
    // Stimulus

    // One worm from input p to output o
    task automatic send_packet(input int p, input int o, input int len, input logic gaps);
        flit_t f;
        flit_t want;
        for (int k = 0; k < len; k++) begin
            f = '0;
            if (k == 0) begin
                f.header.info.source = xy_t'(random_bits(6));
                f.header.info.destination = xy_t'(random_bits(6));
                // Message type tags the sending input
                f.header.info.message_type = 4'(p);
                f.header.reserved = reserved_width'(random_bits(reserved_width));
                f.header.routing = dir_t'(1) << o;
            end else begin
                f.flit[data_width-1:0] = random_bits(data_width);
            end
            f.header.preamble.head = (k == 0);
            f.header.preamble.tail = (k == len - 1);
            want = f;
            if (k == 0) begin
                want.header.routing = expected_route(f.header.routing,
                                                     f.header.info.destination);
            end
            if (gaps && next_random_bit()) begin
                step_clock();
            end
            // No flit while the input queue is full
            while (stop_out[p]) begin
                step_clock();
            end
            data_in[p] = f;
            void_in[p] = 1'b0;
            exp_q[p][o].push_back(want.flit);
            step_clock();
            void_in[p] = 1'b1;
        end
    endtask

    // target -1 picks a random output per packet
    task automatic send_random_packets(input int p, input int count, input int target,
                                       input int min_len, input logic gaps);
        int o;
        int len;
        for (int i = 0; i < count; i++) begin
            o = (target < 0) ? random_other(p) : target;
            len = min_len + int'(random_bits(2)) % (5 - min_len);
            send_packet(p, o, len, gaps);
        end
    endtask

    // Random back-pressure 1 ns after each edge
    always @(posedge clk) begin
        #1;
        stop_in = stop_random ? num_ports'(random_bits(num_ports)) : '0;
    end

    ////////////////////
    // Scoreboard

    task automatic check_flit(input int o, input flit_t want, input flit_t got);
        checks++;
        if (got !== want) begin
            errors++;
            $display("[FAIL] %0t data_%s_o expected %h actual %h",
                     $time, port_name(o), want, got);
        end
    endtask

    task automatic check_output(input int o);
        flit_t got;
        flit_t want;
        int    src;
        got = data_out[o];
        // Nothing may move across an edge with stop high
        if (prev_stop[o]) begin
            checks++;
            if (void_out[o] !== prev_void[o]) begin
                errors++;
                $display("[FAIL] %0t void_o[%0d] expected %b actual %b",
                         $time, o, prev_void[o], void_out[o]);
            end
            if (got !== prev_data[o]) begin
                errors++;
                $display("[FAIL] %0t data_%s_o expected %h actual %h",
                         $time, port_name(o), prev_data[o], got);
            end
        end
        prev_void[o] = void_out[o];
        prev_data[o] = got;
        prev_stop[o] = stop_in[o];
        // Flit consumed on the coming edge
        if (void_out[o] === 1'b0 && stop_in[o] === 1'b0) begin
            src = (worm_src[o] < 0) ? int'(got.header.info.message_type) : worm_src[o];
            if (worm_src[o] < 0 && got.header.preamble.head !== 1'b1) begin
                errors++;
                $display("%0t: output %s sent a payload flit outside any worm",
                         $time, port_name(o));
            end else if (src >= 5 || exp_q[src][o].size() == 0) begin
                errors++;
                $display("%0t: output %s sent a flit that no input had sent to it",
                         $time, port_name(o));
            end else begin
                want.flit = exp_q[src][o].pop_front();
                check_flit(o, want, got);
                worm_src[o] = want.header.preamble.tail ? -1 : src;
            end
        end
    endtask

    // Outputs checked on every falling edge
    always @(negedge clk) begin
        if (!rst) begin
            for (int o = 0; o < num_ports; o++) begin
                check_output(o);
            end
        end
    end

    task automatic wait_drained();
        int waited;
        waited = 0;
        while (pending_flits() != 0 && waited < drain_cycles) begin
            step_clock();
            waited++;
        end
        if (pending_flits() != 0) begin
            errors++;
            $display("%0t: %0d flits were never delivered", $time, pending_flits());
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (errors != errs_before) begin
            tests_failed++;
            $display("%s: %0d errors", name, errors - errs_before);
        end else begin
            $display("%s: ok", name);
        end
    endtask

    ////////////////////
    // Test sequence

    initial begin
        int errs;
        for (int p = 0; p < num_ports; p++) begin
            data_in[p] = '0;
        end
        // Whole reset pulse, rise then release
        wait (rst == 1'b1);
        wait (rst == 1'b0);

        // Reset state
        errs = errors;
        checks++;
        if (void_out !== 5'b11111) begin
            errors++;
            $display("[FAIL] %0t void_o expected %b actual %b", $time, 5'b11111, void_out);
        end
        checks++;
        if (stop_out !== 5'b00000) begin
            errors++;
            $display("[FAIL] %0t stop_o expected %b actual %b", $time, 5'b00000, stop_out);
        end
        report_test("reset state", errs);

        // Every input to every other output in turn
        errs = errors;
        for (int p = 0; p < num_ports; p++) begin
            for (int o = 0; o < num_ports; o++) begin
                if (o != p) begin
                    send_packet(p, o, 1, 1'b0);
                    wait_drained();
                end
            end
        end
        report_test("single-flit packets", errs);

        // Driven after edge n and valid after edge n+1
        errs = errors;
        for (int o = 0; o < 4; o++) begin
            send_packet(port_local, o, 1, 1'b0);
            checks++;
            if (void_out[o] !== 1'b0) begin
                errors++;
                $display("[FAIL] %0t void_o[%0d] expected 0 actual %b", $time, o, void_out[o]);
            end
            wait_drained();
        end
        report_test("uncontended latency", errs);

        errs = errors;
        fork
            send_random_packets(port_north, 6, -1, 2, 1'b0);
            send_random_packets(port_south, 6, -1, 2, 1'b0);
            send_random_packets(port_west, 6, -1, 2, 1'b0);
            send_random_packets(port_east, 6, -1, 2, 1'b0);
            send_random_packets(port_local, 6, -1, 2, 1'b0);
        join
        wait_drained();
        report_test("multi-flit worms", errs);

        // Four inputs fight for the local output
        errs = errors;
        fork
            send_random_packets(port_north, 6, port_local, 1, 1'b0);
            send_random_packets(port_south, 6, port_local, 1, 1'b0);
            send_random_packets(port_west, 6, port_local, 1, 1'b0);
            send_random_packets(port_east, 6, port_local, 1, 1'b0);
        join
        wait_drained();
        report_test("contention", errs);

        errs = errors;
        stop_random = 1'b1;
        fork
            send_random_packets(port_north, 12, -1, 1, 1'b1);
            send_random_packets(port_south, 12, -1, 1, 1'b1);
            send_random_packets(port_west, 12, -1, 1, 1'b1);
            send_random_packets(port_east, 12, -1, 1, 1'b1);
            send_random_packets(port_local, 12, -1, 1, 1'b1);
        join
        stop_random = 1'b0;
        wait_drained();
        report_test("back-pressure", errs);

        $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // Limit from packet count, worst-case worm length and link stalls
    initial begin
        #(watchdog_ns);
        $display("%0t: watchdog expired, the router stopped delivering flits", $time);
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/tb_clock.sv
////////////////////
// Testbench clock and reset
// Free-running clock, reset held for a few edges
////////////////////

`timescale 1ns/10ps
`default_nettype none

module tb_clock #(
    parameter int period_ns = 4,
    parameter int reset_cycles = 5
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #(period_ns / 2) clk_o = ~clk_o;
    end

    // Released just after an edge, like every other input
    initial begin
        rst_o = 1'b1;
        repeat (reset_cycles) @(posedge clk_o);
        #1;
        rst_o = 1'b0;
    end

endmodule

`default_nettype wire

//--- hdl/noc_router.sv
////////////////////
// Five-port mesh router top level
// Input lanes, output lanes and the wiring between them
////////////////////

`timescale 1ns/10ps
`default_nettype none

module noc_router (
    input  logic                          clk,
    input  logic                          rst,
    input  noc_pkg::xy_t                  position_i,
    input  noc_pkg::flit_t                data_n_i,
    input  noc_pkg::flit_t                data_s_i,
    input  noc_pkg::flit_t                data_w_i,
    input  noc_pkg::flit_t                data_e_i,
    input  noc_pkg::flit_t                data_p_i,
    input  logic [noc_pkg::num_ports-1:0] void_i,
    output logic [noc_pkg::num_ports-1:0] stop_o,
    output noc_pkg::flit_t                data_n_o,
    output noc_pkg::flit_t                data_s_o,
    output noc_pkg::flit_t                data_w_o,
    output noc_pkg::flit_t                data_e_o,
    output noc_pkg::flit_t                data_p_o,
    output logic [noc_pkg::num_ports-1:0] void_o,
    input  logic [noc_pkg::num_ports-1:0] stop_i
);

    import noc_pkg::*;

    flit_t [num_ports-1:0]                in_data;
    flit_t [num_ports-1:0]                in_flit;
    dir_t  [num_ports-1:0]                in_next_route;
    logic  [num_ports-1:0]                in_valid;
    dir_t  [num_ports-1:0]                in_request;
    flit_t [num_ports-1:0]                out_data;
    // Pop requests, indexed by output then by input
    logic  [num_ports-1:0][num_ports-1:0] rd_out;
    logic  [num_ports-1:0][num_ports-1:0] rd_in;

    assign in_data[port_north] = data_n_i;
    assign in_data[port_south] = data_s_i;
    assign in_data[port_west] = data_w_i;
    assign in_data[port_east] = data_e_i;
    assign in_data[port_local] = data_p_i;

    assign data_n_o = out_data[port_north];
    assign data_s_o = out_data[port_south];
    assign data_w_o = out_data[port_west];
    assign data_e_o = out_data[port_east];
    assign data_p_o = out_data[port_local];

    for (genvar g = 0; g < num_ports; g++) begin : gen_lane
        // Each input collects its bit from every output
        for (genvar o = 0; o < num_ports; o++) begin : gen_rd
            assign rd_in[g][o] = rd_out[o][g];
        end

        noc_input_port u_in (
            .clk          (clk),
            .rst          (rst),
            .position_i   (position_i),
            .data_i       (in_data[g]),
            .void_i       (void_i[g]),
            .rd_i         (rd_in[g]),
            .flit_o       (in_flit[g]),
            .next_route_o (in_next_route[g]),
            .valid_o      (in_valid[g]),
            .request_o    (in_request[g]),
            .stop_o       (stop_o[g])
        );

        noc_output_port #(
            .out_port (g)
        ) u_out (
            .clk          (clk),
            .rst          (rst),
            .flit_i       (in_flit),
            .next_route_i (in_next_route),
            .valid_i      (in_valid),
            .request_i    (in_request),
            .stop_i       (stop_i[g]),
            .rd_o         (rd_out[g]),
            .data_o       (out_data[g]),
            .void_o       (void_o[g])
        );
    end

endmodule

`default_nettype wire

//--- hdl/noc_output_port.sv
////////////////////
// Router output lane
// Worm FSM, switch selection
// Head route rewrite, output register
////////////////////

`timescale 1ns/10ps
`default_nettype none

module noc_output_port #(
    parameter int unsigned out_port = 0
) (
    input  logic                                           clk,
    input  logic                                           rst,
    input  noc_pkg::flit_t [noc_pkg::num_ports-1:0]        flit_i,
    input  noc_pkg::dir_t  [noc_pkg::num_ports-1:0]        next_route_i,
    input  logic           [noc_pkg::num_ports-1:0]        valid_i,
    input  noc_pkg::dir_t  [noc_pkg::num_ports-1:0]        request_i,
    input  logic                                           stop_i,
    output logic           [noc_pkg::num_ports-1:0]        rd_o,
    output noc_pkg::flit_t                                 data_o,
    output logic                                           void_o
);

    import noc_pkg::*;

    logic [num_ports-2:0] req_other;
    logic [num_ports-2:0] grant;
    logic                 grant_valid;
    logic [num_ports-1:0] grant_sel;
    logic [num_ports-1:0] sel;
    logic [num_ports-1:0] saved_sel;
    logic                 payload_state;
    flit_t                xbar_flit;
    flit_t                out_flit;
    dir_t                 xbar_next_route;
    logic                 xbar_valid;
    logic                 forwarding;
    logic                 head_fwd;
    logic                 tail_fwd;

    ////////////////////
    // Arbitration

    // Own index is skipped, a flit never turns back
    for (genvar j = 0; j < num_ports; j++) begin : gen_map
        if (j < out_port) begin : gen_below
            assign req_other[j] = request_i[j][out_port];
            assign grant_sel[j] = grant[j];
        end else if (j > out_port) begin : gen_above
            assign req_other[j-1] = request_i[j][out_port];
            assign grant_sel[j] = grant[j-1];
        end else begin : gen_self
            assign grant_sel[j] = 1'b0;
        end
    end

    noc_output_arbiter u_arbiter (
        .clk           (clk),
        .rst           (rst),
        .request_i     (req_other),
        .head_fwd_i    (head_fwd),
        .tail_fwd_i    (tail_fwd),
        .grant_o       (grant),
        .grant_valid_o (grant_valid)
    );

    ////////////////////
    // Switching

    // New grant in head state, saved input during the worm
    always_comb begin
        if (payload_state) begin
            sel = saved_sel;
        end else if (grant_valid & ~stop_i) begin
            sel = grant_sel;
        end else begin
            sel = '0;
        end
    end

    always_comb begin
        xbar_flit = '0;
        xbar_next_route = '0;
        xbar_valid = 1'b0;
        for (int j = 0; j < num_ports; j++) begin
            if (sel[j]) begin
                xbar_flit = flit_i[j];
                xbar_next_route = next_route_i[j];
                xbar_valid = valid_i[j];
            end
        end
    end

    // Head carries the route for the next router
    always_comb begin
        out_flit = xbar_flit;
        if (~payload_state) begin
            out_flit.header.routing = xbar_next_route;
        end
    end

    assign rd_o = sel & {num_ports{~stop_i}};
    assign forwarding = xbar_valid & ~stop_i;
    assign head_fwd = forwarding & xbar_flit.header.preamble.head;
    assign tail_fwd = forwarding & xbar_flit.header.preamble.tail;

    // Worm FSM, payload state until the tail leaves
    always_ff @(posedge clk) begin
        if (rst) begin
            payload_state <= 1'b0;
            saved_sel <= '0;
        end else begin
            if (tail_fwd) begin
                payload_state <= 1'b0;
            end else if (head_fwd) begin
                payload_state <= 1'b1;
            end
            if (head_fwd) begin
                saved_sel <= sel;
            end
        end
    end

    ////////////////////
    // Output register

    // Both hold while the next router stops us
    always_ff @(posedge clk) begin
        if (rst) begin
            void_o <= 1'b1;
        end else if (~stop_i) begin
            void_o <= ~forwarding;
        end
    end

    always_ff @(posedge clk) begin
        if (forwarding) begin
            data_o <= out_flit;
        end
    end

endmodule

`default_nettype wire

//--- hdl/noc_output_arbiter.sv
////////////////////
// Round-robin output arbiter
// Four competing inputs, grant held per worm
////////////////////

`timescale 1ns/10ps
`default_nettype none

module noc_output_arbiter (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [noc_pkg::num_ports-2:0] request_i,
    input  logic                          head_fwd_i,
    input  logic                          tail_fwd_i,
    output logic [noc_pkg::num_ports-2:0] grant_o,
    output logic                          grant_valid_o
);

    import noc_pkg::*;

    logic [arb_width-1:0] ptr;
    logic [arb_width-1:0] cand;
    logic [arb_width-1:0] grant_idx;
    logic [arb_width-1:0] held_idx;
    logic [arb_width-1:0] done_idx;

    // First requester at or after the pointer
    always_comb begin
        grant_o = '0;
        grant_idx = ptr;
        grant_valid_o = 1'b0;
        cand = ptr;
        for (int i = 0; i < num_ports - 1; i++) begin
            cand = ptr + arb_width'(i);
            if (~grant_valid_o && request_i[cand]) begin
                grant_o[cand] = 1'b1;
                grant_idx = cand;
                grant_valid_o = 1'b1;
            end
        end
    end

    // Winner of the worm in flight
    always_ff @(posedge clk) begin
        if (rst) begin
            held_idx <= '0;
        end else if (head_fwd_i) begin
            held_idx <= grant_idx;
        end
    end

    // Single-flit packets finish on the head edge
    assign done_idx = head_fwd_i ? grant_idx : held_idx;

    // Priority rotates past the winner once its tail leaves
    always_ff @(posedge clk) begin
        if (rst) begin
            ptr <= '0;
        end else if (tail_fwd_i) begin
            ptr <= done_idx + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- hdl/noc_input_port.sv
////////////////////
// Router input lane
// Queue, head decode, saved request
// Look-ahead route and stop level
////////////////////

`timescale 1ns/10ps
`default_nettype none

module noc_input_port (
    input  logic                          clk,
    input  logic                          rst,
    input  noc_pkg::xy_t                  position_i,
    input  noc_pkg::flit_t                data_i,
    input  logic                          void_i,
    input  logic [noc_pkg::num_ports-1:0] rd_i,
    output noc_pkg::flit_t                flit_o,
    output noc_pkg::dir_t                 next_route_o,
    output logic                          valid_o,
    output noc_pkg::dir_t                 request_o,
    output logic                          stop_o
);

    import noc_pkg::*;

    logic empty;
    logic full;
    logic rd_any;
    logic valid_head;
    dir_t saved_request;

    // Any output may pop this lane
    assign rd_any = |rd_i;

    noc_input_fifo u_fifo (
        .clk     (clk),
        .rst     (rst),
        .wr_i    (~void_i),
        .data_i  (data_i),
        .rd_i    (rd_any),
        .data_o  (flit_o),
        .empty_o (empty),
        .full_o  (full)
    );

    // Queued flit or a flit on the bypass
    assign valid_o = ~empty | ~void_i;
    assign valid_head = valid_o & flit_o.header.preamble.head;

    // Request is kept for the body of the worm
    always_ff @(posedge clk) begin
        if (rst) begin
            saved_request <= '0;
        end else if (valid_o & flit_o.header.preamble.tail) begin
            saved_request <= '0;
        end else if (valid_head) begin
            saved_request <= flit_o.header.routing;
        end
    end

    assign request_o = valid_head ? flit_o.header.routing : saved_request;

    noc_lookahead_route u_route (
        .position_i    (position_i),
        .destination_i (flit_o.header.info.destination),
        .route_i       (flit_o.header.routing),
        .next_route_o  (next_route_o)
    );

    assign stop_o = full;

endmodule

`default_nettype wire

//--- hdl/noc_lookahead_route.sv
////////////////////
// Look-ahead XY routing
// Route the next router must use
////////////////////

`timescale 1ns/10ps
`default_nettype none

module noc_lookahead_route (
    input  noc_pkg::xy_t  position_i,
    input  noc_pkg::xy_t  destination_i,
    input  noc_pkg::dir_t route_i,
    output noc_pkg::dir_t next_route_o
);

    import noc_pkg::*;

    xy_t next_pos;

    // Coordinate of the router this flit moves to
    always_comb begin
        next_pos = position_i;
        case (route_i)
            go_north: next_pos.y = position_i.y - 3'd1;
            go_south: next_pos.y = position_i.y + 3'd1;
            go_west:  next_pos.x = position_i.x - 3'd1;
            go_east:  next_pos.x = position_i.x + 3'd1;
            default: begin
                // Local keeps the position
            end
        endcase
    end

    // X first, then Y, then eject
    always_comb begin
        if (destination_i.x > next_pos.x) begin
            next_route_o = go_east;
        end else if (destination_i.x < next_pos.x) begin
            next_route_o = go_west;
        end else if (destination_i.y > next_pos.y) begin
            next_route_o = go_south;
        end else if (destination_i.y < next_pos.y) begin
            next_route_o = go_north;
        end else begin
            next_route_o = go_local;
        end
    end

endmodule

`default_nettype wire

//--- hdl/noc_input_fifo.sv
////////////////////
// Input flit queue
// Circular buffer with bypass when empty
////////////////////

`timescale 1ns/10ps
`default_nettype none

module noc_input_fifo (
    input  logic           clk,
    input  logic           rst,
    input  logic           wr_i,
    input  noc_pkg::flit_t data_i,
    input  logic           rd_i,
    output noc_pkg::flit_t data_o,
    output logic           empty_o,
    output logic           full_o
);

    import noc_pkg::*;

    flit_t mem [queue_depth];

    logic [ptr_width-1:0] wr_ptr;
    logic [ptr_width-1:0] rd_ptr;
    logic [ptr_width:0]   count;
    logic                 push;
    logic                 pop;

    assign empty_o = count == '0;
    assign full_o = count == (ptr_width + 1)'(queue_depth);

    // Front of queue, or the incoming flit when nothing is queued
    assign data_o = empty_o ? data_i : mem[rd_ptr];

    // Empty queue with a read takes the flit straight through
    assign push = wr_i & ~full_o & ~(empty_o & rd_i);
    assign pop = rd_i & ~empty_o;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Count moves only when exactly one side is active
            if (push & ~pop) begin
                count <= count + 1'b1;
            end else if (pop & ~push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/noc_pkg.sv
////////////////////
// Shared definitions for the mesh router
// Flit widths, queue depth and port indices
// One-hot directions and coordinate type
// Header and flit types
////////////////////

`default_nettype none

package noc_pkg;

    // Flit sizes, preamble excluded from data_width
    localparam int unsigned data_width = 32;
    localparam int unsigned flit_width = data_width + 2;

    // Router shape
    localparam int unsigned num_ports = 5;
    localparam int unsigned queue_depth = 4;
    localparam int unsigned ptr_width = $clog2(queue_depth);
    localparam int unsigned arb_width = $clog2(num_ports - 1);

    // Port indices
    localparam int unsigned port_north = 0;
    localparam int unsigned port_south = 1;
    localparam int unsigned port_west = 2;
    localparam int unsigned port_east = 3;
    localparam int unsigned port_local = 4;

    // Bit n set means leave by port n
    typedef logic [num_ports-1:0] dir_t;

    localparam dir_t go_north = 5'b00001;
    localparam dir_t go_south = 5'b00010;
    localparam dir_t go_west = 5'b00100;
    localparam dir_t go_east = 5'b01000;
    localparam dir_t go_local = 5'b10000;

    typedef struct packed {
        logic [2:0] x;
        logic [2:0] y;
    } xy_t;

    // Head and tail both set on a single-flit packet
    typedef struct packed {
        logic head;
        logic tail;
    } preamble_t;

    typedef struct packed {
        xy_t        source;
        xy_t        destination;
        logic [3:0] message_type;
    } packet_info_t;

    localparam int unsigned reserved_width = data_width - $bits(packet_info_t) - $bits(dir_t);

    // Routing sits in the lowest bits
    typedef struct packed {
        preamble_t                 preamble;
        packet_info_t              info;
        logic [reserved_width-1:0] reserved;
        dir_t                      routing;
    } header_t;

    // Header view on head flits, raw word on payload
    typedef union packed {
        header_t               header;
        logic [flit_width-1:0] flit;
    } flit_t;

endpackage

`default_nettype wire
